// File: cube_top.f
+incdir+verilog
verilog/cube_pkg.sv
verilog/cube_sequencer.sv
verilog/line_drawer.sv
verilog/framebuffer.sv
verilog/raster_scan.sv
verilog/cube_top.sv
bench/cube_checker.sv
bench/cube_tb.sv

// File: bench/cube_tb.sv
// cube renderer testbench
// random colour draw requests with idle gaps, checked frame by frame by cube_checker

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module cube_tb;
    import cube_pkg::*;

    localparam int FRAME_CYCLES    = `CUBE_H_TOTAL * `CUBE_V_TOTAL;
    localparam int REQ_CNT         = 8;
    localparam int WATCHDOG_FRAMES = 40;   // initial frames, 8 x (draw + gap), final frames

    logic      clk_100m;
    logic      reset;
    draw_req_t req;
    logic      req_valid;
    logic      req_ready;
    scan_pix_t pix;
    logic      pix_valid;
    logic      frame_start;
    logic      busy;
    int        errors;
    int        frames_checked;
    int        completed;
    logic      clear_seen;
    logic      last_seen;
    int        bench_errors;

    cube_top u_dut (
        .clk_100m,
        .reset,
        .req,
        .req_valid,
        .req_ready,
        .pix,
        .pix_valid,
        .frame_start,
        .busy
    );

    cube_checker u_chk (
        .clk_100m,
        .reset,
        .req,
        .req_valid,
        .req_ready,
        .pix,
        .pix_valid,
        .frame_start,
        .busy,
        .errors,
        .frames_checked,
        .completed,
        .clear_seen,
        .last_seen
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // frame_start is registered, so it is steady at the falling edge
    task automatic wait_frames(input int n);
        repeat (n) begin
            @(negedge clk_100m);
            while (!frame_start) @(negedge clk_100m);
        end
    endtask

    task automatic send_request(input cidx_t c);
        @(negedge clk_100m);
        req.cidx  = c;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk_100m);
        @(negedge clk_100m);  // transfer happened on the rising edge in between
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk_100m);
        while (busy) @(negedge clk_100m);
    endtask

    initial begin
        int gap;
        reset        = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        bench_errors = 0;
        void'($urandom(32'h7eaf2a4d));
        repeat (5) @(posedge clk_100m);
        @(negedge clk_100m);
        reset = 1'b0;

        wait_frames(2);  // one full frame of the cleared buffer
        for (int i = 0; i < REQ_CNT; i++) begin
            send_request(cidx_t'($urandom));
            wait_idle();
            gap = $urandom % 4;
            wait_frames(gap);
        end
        wait_idle();
        wait_frames(2);
        @(negedge clk_100m);

        if (completed != REQ_CNT) begin
            $display("CHECK FAILED completed_requests: expected %0d, actual %0d",
                     REQ_CNT, completed);
            bench_errors++;
        end
        if (!clear_seen) begin
            $display("ERROR: no clean frame of the cleared buffer was compared");
            bench_errors++;
        end
        if (!last_seen) begin
            $display("ERROR: the final cube image never appeared in a clean frame");
            bench_errors++;
        end
        $display("errors: %0d (checker %0d, bench %0d), frames compared: %0d",
                 errors + bench_errors, errors, bench_errors, frames_checked);
        if (errors + bench_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(1.0 * WATCHDOG_FRAMES * FRAME_CYCLES * 10.0);
        $display("ERROR: watchdog expired after %0d frame periods", WATCHDOG_FRAMES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/cube_checker.sv
// cube renderer checker
// paints a model image on every finished request and compares clean frames with it

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module cube_checker (
    input  wire logic                clk_100m,
    input  wire logic                reset,
    input  wire cube_pkg::draw_req_t req,
    input  wire logic                req_valid,
    input  wire logic                req_ready,
    input  wire cube_pkg::scan_pix_t pix,
    input  wire logic                pix_valid,
    input  wire logic                frame_start,
    input  wire logic                busy,
    output int                       errors,
    output int                       frames_checked,
    output int                       completed,
    output logic                     clear_seen,
    output logic                     last_seen
);
    import cube_pkg::*;

    localparam int NPIX = `CUBE_FB_WIDTH * `CUBE_FB_HEIGHT;
    localparam int FRAME_CYCLES = `CUBE_H_TOTAL * `CUBE_V_TOTAL;

    // cube edges as x0, y0, x1, y1
    localparam logic [0:35][7:0] EDGES = {
        8'd26, 8'd18, 8'd46, 8'd18,   8'd46, 8'd18, 8'd46, 8'd38,
        8'd46, 8'd38, 8'd26, 8'd38,   8'd26, 8'd38, 8'd26, 8'd18,
        8'd26, 8'd38, 8'd18, 8'd30,   8'd18, 8'd30, 8'd18, 8'd10,
        8'd18, 8'd10, 8'd26, 8'd18,   8'd18, 8'd10, 8'd38, 8'd10,
        8'd38, 8'd10, 8'd46, 8'd18
    };

    cidx_t model [NPIX];
    cidx_t frame [NPIX];     // pixels of the frame in progress
    cidx_t colours [$];      // accepted, not yet drawn
    logic  busy_q;
    logic  clean;            // busy low since this frame began
    logic  in_frame;
    int    beats;
    int    cycles;
    int    paints;

    initial begin
        errors         = 0;
        frames_checked = 0;
        completed      = 0;
    end

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic fail(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        errors++;
    endtask

    // integer Bresenham, both endpoints painted
    task automatic paint_line(input int x0, input int y0, input int x1, input int y1,
                              input cidx_t c);
        int dx, dy, sx, sy, err, e2;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        sx  = (x1 > x0) ? 1 : -1;
        sy  = (y1 > y0) ? 1 : -1;
        err = dx + dy;
        forever begin
            model[y0 * `CUBE_FB_WIDTH + x0] = c;
            if (x0 == x1 && y0 == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x0  += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y0  += sy;
            end
        end
    endtask

    task automatic compare_frame();
        string name;
        int    bad;
        name = (paints == 0) ? "clear" : ((paints == 1) ? "geometry" : "overdraw");
        bad  = 0;
        for (int i = 0; i < NPIX; i++) begin
            if (frame[i] !== model[i]) begin
                if (bad < 4) begin  // first few per frame only
                    $display("CHECK FAILED %s pixel (%0d,%0d): expected %0d, actual %0d",
                             name, i % `CUBE_FB_WIDTH, i / `CUBE_FB_WIDTH, model[i], frame[i]);
                end
                bad++;
            end
        end
        errors += bad;
        frames_checked++;
        if (paints == 0) clear_seen = 1'b1;
        last_seen = 1'b1;
    endtask

    always @(posedge clk_100m) begin
        if (reset) begin
            for (int i = 0; i < NPIX; i++) model[i] = '0;
            colours.delete();
            busy_q     = 1'b0;
            clean      = 1'b0;
            in_frame   = 1'b0;
            clear_seen = 1'b0;
            last_seen  = 1'b0;
            paints     = 0;
        end else begin
            if (req_ready && busy) fail("req_ready high while busy");
            if (req_valid && req_ready) begin
                colours.push_back(req.cidx);
            end
            if (frame_start) begin
                if (in_frame) begin
                    check_val("frame_period", FRAME_CYCLES, cycles);
                    check_val("frame_beats", NPIX, beats);
                    if (clean && beats == NPIX) compare_frame();
                end
                in_frame = 1'b1;
                cycles   = 0;
                beats    = 0;
                clean    = !busy;
            end
            if (busy) clean = 1'b0;
            if (busy_q && !busy) begin  // request finished
                if (colours.size() == 0) begin
                    fail("busy fell with no accepted request pending");
                end else begin
                    for (int i = 0; i < `CUBE_LINE_CNT; i++)
                        paint_line(EDGES[4*i], EDGES[4*i+1], EDGES[4*i+2], EDGES[4*i+3],
                                   colours[0]);
                    void'(colours.pop_front());
                    paints++;
                    completed++;
                    last_seen = 1'b0;
                end
            end
            if (pix_valid && in_frame) begin
                check_val("scan_order_x", beats % `CUBE_FB_WIDTH, int'(pix.x));
                check_val("scan_order_y", beats / `CUBE_FB_WIDTH, int'(pix.y));
                if (beats < NPIX) frame[beats] = pix.cidx;
                beats++;
            end
            cycles++;
            busy_q = busy;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cube_top.sv
// cube renderer top
// sequencer and line drawer fill the framebuffer, the scanner reads it out

`default_nettype none
`timescale 1ns/10ps

module cube_top (
    input  wire logic                clk_100m,
    input  wire logic                reset,
    input  wire cube_pkg::draw_req_t req,
    input  wire logic                req_valid,
    output logic                     req_ready,
    output cube_pkg::scan_pix_t      pix,
    output logic                     pix_valid,
    output logic                     frame_start,
    output logic                     busy
);
    import cube_pkg::*;

    line_t    line;
    logic     line_valid;
    logic     line_ready;
    pixel_t   wr;          // drawer to framebuffer
    logic     wr_valid;
    logic     wr_ready;
    logic     rd_en;       // scanner read port
    fb_addr_t rd_addr;
    cidx_t    rd_data;

    cube_sequencer u_seq (
        .clk_100m,
        .reset,
        .req,
        .req_valid,
        .req_ready,
        .line,
        .line_valid,
        .line_ready,
        .busy
    );

    line_drawer u_draw (
        .clk_100m,
        .reset,
        .line,
        .line_valid,
        .line_ready,
        .wr,
        .wr_valid,
        .wr_ready
    );

    framebuffer u_fb (
        .clk_100m,
        .reset,
        .wr,
        .wr_valid,
        .wr_ready,
        .rd_en,
        .rd_addr,
        .rd_data
    );

    raster_scan u_scan (
        .clk_100m,
        .reset,
        .rd_en,
        .rd_addr,
        .rd_data,
        .pix,
        .pix_valid,
        .frame_start
    );

endmodule

`default_nettype wire

// File: verilog/raster_scan.sv
// raster scanner
// walks active and blanking positions, reads the framebuffer and streams pixels

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module raster_scan (
    input  wire logic            clk_100m,
    input  wire logic            reset,
    output logic                 rd_en,
    output cube_pkg::fb_addr_t   rd_addr,
    input  wire cube_pkg::cidx_t rd_data,
    output cube_pkg::scan_pix_t  pix,
    output logic                 pix_valid,
    output logic                 frame_start
);
    import cube_pkg::*;

    localparam int HW = $clog2(`CUBE_H_TOTAL);
    localparam int VW = $clog2(`CUBE_V_TOTAL);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          active;
    fb_addr_t      addr_cnt;   // running read address
    coord_t        px;         // position delayed to meet rd_data
    coord_t        py;

    assign active = (h_cnt < `CUBE_FB_WIDTH) && (v_cnt < `CUBE_FB_HEIGHT);

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            addr_cnt    <= '0;
            pix_valid   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pix_valid   <= active;
            frame_start <= (h_cnt == '0) && (v_cnt == '0);
            if (h_cnt == HW'(`CUBE_H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == VW'(`CUBE_V_TOTAL - 1)) v_cnt <= '0;
                else v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (h_cnt == HW'(`CUBE_H_TOTAL - 1) && v_cnt == VW'(`CUBE_V_TOTAL - 1)) begin
                addr_cnt <= '0;  // new frame
            end else if (active) begin
                addr_cnt <= addr_cnt + 12'd1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        px <= coord_t'(h_cnt);
        py <= coord_t'(v_cnt);
    end

    assign rd_en   = active;
    assign rd_addr = addr_cnt;
    assign pix     = '{x: px, y: py, cidx: rd_data};

    // running address tracks the scan position across the frame
    a_addr_match: assert property (@(posedge clk_100m) disable iff (reset)
        rd_en |-> rd_addr == fb_addr_t'(v_cnt * `CUBE_FB_WIDTH + h_cnt));

endmodule

`default_nettype wire

// File: verilog/framebuffer.sv
// indexed-colour framebuffer, single port
// clears itself after reset, scan reads win over drawer writes

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module framebuffer (
    input  wire logic             clk_100m,
    input  wire logic             reset,
    input  wire cube_pkg::pixel_t  wr,
    input  wire logic             wr_valid,
    output logic                  wr_ready,
    input  wire logic             rd_en,
    input  wire cube_pkg::fb_addr_t rd_addr,
    output cube_pkg::cidx_t       rd_data
);
    import cube_pkg::*;

    localparam int DEPTH = `CUBE_FB_WIDTH * `CUBE_FB_HEIGHT;

    cidx_t    mem [DEPTH];
    logic     clr_active;   // clear pass owns the port
    fb_addr_t clr_addr;
    fb_addr_t wr_addr;
    logic     mem_we;
    fb_addr_t mem_waddr;
    cidx_t    mem_wdata;

    always_comb begin
        wr_addr   = fb_addr_t'(fb_addr_t'(wr.y) * `CUBE_FB_WIDTH + fb_addr_t'(wr.x));
        wr_ready  = !clr_active && !rd_en;  // scan has priority
        mem_we    = clr_active || (wr_valid && wr_ready);
        mem_waddr = clr_active ? clr_addr : wr_addr;
        mem_wdata = clr_active ? cidx_t'(0) : wr.cidx;
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            clr_active <= 1'b1;
            clr_addr   <= '0;
        end else if (clr_active) begin
            clr_addr <= clr_addr + 12'd1;
            if (clr_addr == fb_addr_t'(DEPTH - 1)) clr_active <= 1'b0;
        end
    end

    // one access per cycle, reads while clearing see zero
    always_ff @(posedge clk_100m) begin
        if (mem_we) mem[mem_waddr] <= mem_wdata;
        if (rd_en) rd_data <= clr_active ? cidx_t'(0) : mem[rd_addr];
    end

    // a stalled drawer pixel stays put until the port frees up
    a_wr_hold: assert property (@(posedge clk_100m) disable iff (reset)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr)));

endmodule

`default_nettype wire

// File: verilog/line_drawer.sv
// Bresenham line engine
// one setup cycle per edge, then one pixel per write handshake, endpoints included

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module line_drawer (
    input  wire logic           clk_100m,
    input  wire logic           reset,
    input  wire cube_pkg::line_t line,
    input  wire logic           line_valid,
    output logic                line_ready,
    output cube_pkg::pixel_t    wr,
    output logic                wr_valid,
    input  wire logic           wr_ready
);
    import cube_pkg::*;

    typedef enum logic [1:0] {D_IDLE, D_SETUP, D_DRAW} state_t;

    state_t             state;
    line_t              ln;          // latched edge
    coord_t             x;
    coord_t             y;
    logic               x_neg;       // step direction
    logic               y_neg;
    logic signed [9:0]  dx_c;        // |x1 - x0|
    logic signed [9:0]  dy_c;        // -|y1 - y0|
    logic signed [9:0]  dx;
    logic signed [9:0]  dy;
    logic signed [10:0] err;
    logic signed [10:0] err_nxt;
    logic signed [11:0] e2;
    logic               step_x;
    logic               step_y;
    logic               last;        // at the far endpoint

    always_comb begin
        if (ln.x1 >= ln.x0) dx_c = 10'(ln.x1) - 10'(ln.x0);
        else dx_c = 10'(ln.x0) - 10'(ln.x1);
        if (ln.y1 >= ln.y0) dy_c = 10'(ln.y0) - 10'(ln.y1);
        else dy_c = 10'(ln.y1) - 10'(ln.y0);

        e2      = {err, 1'b0};
        step_x  = (e2 >= dy);
        step_y  = (e2 <= dx);
        err_nxt = err + (step_x ? 11'(dy) : 11'sd0) + (step_y ? 11'(dx) : 11'sd0);
        last    = (x == ln.x1) && (y == ln.y1);
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state <= D_IDLE;
        end else begin
            case (state)
                D_IDLE:  if (line_valid) state <= D_SETUP;
                D_SETUP: state <= D_DRAW;
                default: if (wr_ready && last) state <= D_IDLE;  // D_DRAW
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == D_IDLE && line_valid) ln <= line;

        if (state == D_SETUP) begin
            x     <= ln.x0;
            y     <= ln.y0;
            dx    <= dx_c;
            dy    <= dy_c;
            err   <= 11'(dx_c) + 11'(dy_c);
            x_neg <= (ln.x1 < ln.x0);
            y_neg <= (ln.y1 < ln.y0);
        end else if (state == D_DRAW && wr_ready && !last) begin
            if (step_x) x <= x_neg ? x - 8'sd1 : x + 8'sd1;
            if (step_y) y <= y_neg ? y - 8'sd1 : y + 8'sd1;
            err <= err_nxt;
        end
    end

    assign line_ready = (state == D_IDLE);
    assign wr_valid   = (state == D_DRAW);
    assign wr         = '{x: x, y: y, cidx: ln.cidx};

    // framebuffer has no clipping, every offered pixel must land inside it
    a_pix_inside: assert property (@(posedge clk_100m) disable iff (reset)
        wr_valid |-> (x >= 0 && x < `CUBE_FB_WIDTH && y >= 0 && y < `CUBE_FB_HEIGHT));

endmodule

`default_nettype wire

// File: verilog/cube_sequencer.sv
// cube sequencer
// takes a draw request and hands the nine cube edges to the line drawer

`default_nettype none
`timescale 1ns/10ps

`include "cube_defines.svh"

module cube_sequencer (
    input  wire logic              clk_100m,
    input  wire logic              reset,
    input  wire cube_pkg::draw_req_t req,
    input  wire logic              req_valid,
    output logic                   req_ready,
    output cube_pkg::line_t        line,
    output logic                   line_valid,
    input  wire logic              line_ready,
    output logic                   busy
);
    import cube_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_ISSUE, S_FINISH} state_t;

    state_t      state;
    logic [3:0]  line_idx;   // current edge
    cidx_t       cidx_q;     // colour of the running request

    // fixed cube edges, reference coordinates scaled by 1/5
    function automatic line_t edge_line(input logic [3:0] idx, input cidx_t c);
        line_t l;
        case (idx)
            4'd0: l = '{x0: 8'sd26, y0: 8'sd18, x1: 8'sd46, y1: 8'sd18, cidx: c};
            4'd1: l = '{x0: 8'sd46, y0: 8'sd18, x1: 8'sd46, y1: 8'sd38, cidx: c};
            4'd2: l = '{x0: 8'sd46, y0: 8'sd38, x1: 8'sd26, y1: 8'sd38, cidx: c};
            4'd3: l = '{x0: 8'sd26, y0: 8'sd38, x1: 8'sd26, y1: 8'sd18, cidx: c};
            4'd4: l = '{x0: 8'sd26, y0: 8'sd38, x1: 8'sd18, y1: 8'sd30, cidx: c};
            4'd5: l = '{x0: 8'sd18, y0: 8'sd30, x1: 8'sd18, y1: 8'sd10, cidx: c};
            4'd6: l = '{x0: 8'sd18, y0: 8'sd10, x1: 8'sd26, y1: 8'sd18, cidx: c};
            4'd7: l = '{x0: 8'sd18, y0: 8'sd10, x1: 8'sd38, y1: 8'sd10, cidx: c};
            4'd8: l = '{x0: 8'sd38, y0: 8'sd10, x1: 8'sd46, y1: 8'sd18, cidx: c};
            default: l = '{x0: 8'sd0, y0: 8'sd0, x1: 8'sd0, y1: 8'sd0, cidx: c};
        endcase
        return l;
    endfunction

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state      <= S_IDLE;
            req_ready  <= 1'b0;
            line_valid <= 1'b0;
            busy       <= 1'b0;
            line_idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid && req_ready) begin
                        req_ready <= 1'b0;
                        busy      <= 1'b1;
                        line_idx  <= '0;
                        state     <= S_LOAD;
                    end else begin
                        req_ready <= 1'b1;
                    end
                end
                S_LOAD: begin  // edge registered here, offered next cycle
                    line_valid <= 1'b1;
                    state      <= S_ISSUE;
                end
                S_ISSUE: begin
                    if (line_ready) begin
                        line_valid <= 1'b0;
                        if (line_idx == 4'(`CUBE_LINE_CNT - 1)) begin
                            state <= S_FINISH;
                        end else begin
                            line_idx <= line_idx + 4'd1;
                            state    <= S_LOAD;
                        end
                    end
                end
                default: begin  // S_FINISH, drawer still on the last edge
                    if (line_ready) begin
                        busy      <= 1'b0;
                        req_ready <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == S_IDLE && req_valid && req_ready) cidx_q <= req.cidx;
        if (state == S_LOAD) line <= edge_line(line_idx, cidx_q);
    end

    // edge index never leaves the table while a request runs
    a_line_idx: assert property (@(posedge clk_100m) disable iff (reset)
        busy |-> line_idx < `CUBE_LINE_CNT);

endmodule

`default_nettype wire

// File: verilog/cube_pkg.sv
// cube renderer types
// coordinates, colour indices and the structs passed between blocks

`default_nettype none

`include "cube_defines.svh"

package cube_pkg;

    typedef logic signed [7:0]       coord_t;    // screen coordinate
    typedef logic [`CUBE_CIDX_W-1:0] cidx_t;     // colour index
    typedef logic [11:0]             fb_addr_t;  // row * width + column

    typedef struct packed {
        cidx_t cidx;
    } draw_req_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } scan_pix_t;

endpackage

`default_nettype wire

// File: verilog/cube_defines.svh
// cube renderer sizes
// framebuffer geometry, scan totals and drawing constants

`ifndef CUBE_DEFINES_SVH
`define CUBE_DEFINES_SVH

// framebuffer size in pixels
`define CUBE_FB_WIDTH   64
`define CUBE_FB_HEIGHT  48

// scan positions per line and lines per frame, blanking included
`define CUBE_H_TOTAL    80
`define CUBE_V_TOTAL    52

`define CUBE_LINE_CNT   9   // edges of the wire-frame cube
`define CUBE_CIDX_W     4   // colour index bits

`endif
